// File: hw/video_out_pkg.sv
// Video output stage package
// Channel width, extra-output mode codes, BT.709 YPbPr coefficients
// and the pixel word shared between the converter and the DAC formatter

package video_out_pkg;

    localparam int PIX_W = 8;

    // Extra analog output modes
    localparam logic [1:0] MODE_RGBHV = 2'd0;
    localparam logic [1:0] MODE_RGBCS = 2'd1;
    localparam logic [1:0] MODE_RGSB  = 2'd2;
    localparam logic [1:0] MODE_YPBPR = 2'd3;

    // BT.709 coefficients, scaled by 256
    localparam logic signed [8:0] CSC_Y_R  = 9'sd47;
    localparam logic signed [8:0] CSC_Y_G  = 9'sd157;
    localparam logic signed [8:0] CSC_Y_B  = 9'sd16;
    localparam logic signed [8:0] CSC_PB_R = -9'sd26;
    localparam logic signed [8:0] CSC_PB_G = -9'sd86;
    localparam logic signed [8:0] CSC_PB_B = 9'sd112;
    localparam logic signed [8:0] CSC_PR_R = 9'sd112;
    localparam logic signed [8:0] CSC_PR_G = -9'sd102;
    localparam logic signed [8:0] CSC_PR_B = -9'sd10;

    localparam int CSC_SHIFT  = 8;
    localparam int CHROMA_OFS = 128;

    typedef struct packed {
        logic [PIX_W-1:0] r;
        logic [PIX_W-1:0] g;
        logic [PIX_W-1:0] b;
    } rgb_t;

    // Component order follows the DAC channels: R carries Pr, G carries Y, B carries Pb
    typedef struct packed {
        logic [PIX_W-1:0] pr;
        logic [PIX_W-1:0] y;
        logic [PIX_W-1:0] pb;
    } ypbpr_t;

    typedef union packed {
        rgb_t   rgb;
        ypbpr_t ypbpr;
    } pixel_u;

endpackage

// File: hw/osd_mixer.sv
// OSD overlay and HDMI transmitter output registers
// First stage replaces the pixel by the expanded OSD colour,
// second stage drives the transmitter pins

module osd_mixer import video_out_pkg::*; (
    input  logic             pclk_out,
    input  logic             po_reset_n,
    input  logic [PIX_W-1:0] r_i,
    input  logic [PIX_W-1:0] g_i,
    input  logic [PIX_W-1:0] b_i,
    input  logic             hsync_i,
    input  logic             vsync_i,
    input  logic             de_i,
    input  logic             osd_enable_i,
    input  logic [2:0]       osd_color_i,
    output pixel_u           pixel_o,
    output logic             hsync_o,
    output logic             vsync_o,
    output logic             de_o,
    output logic [PIX_W-1:0] hdmi_r_o,
    output logic [PIX_W-1:0] hdmi_g_o,
    output logic [PIX_W-1:0] hdmi_b_o,
    output logic             hdmi_hsync_o,
    output logic             hdmi_vsync_o,
    output logic             hdmi_de_o
);

    // Overlay stage, also feeds the analog path
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pixel_o <= '0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            de_o    <= 1'b0;
        end else begin
            if (osd_enable_i) begin
                pixel_o.rgb.r <= {PIX_W{osd_color_i[2]}};
                pixel_o.rgb.g <= {PIX_W{osd_color_i[1]}};
                pixel_o.rgb.b <= {PIX_W{osd_color_i[0]}};
            end else begin
                pixel_o.rgb.r <= r_i;
                pixel_o.rgb.g <= g_i;
                pixel_o.rgb.b <= b_i;
            end
            hsync_o <= hsync_i;
            vsync_o <= vsync_i;
            de_o    <= de_i;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmi_r_o     <= '0;
            hdmi_g_o     <= '0;
            hdmi_b_o     <= '0;
            hdmi_hsync_o <= 1'b0;
            hdmi_vsync_o <= 1'b0;
            hdmi_de_o    <= 1'b0;
        end else begin
            hdmi_r_o     <= pixel_o.rgb.r;
            hdmi_g_o     <= pixel_o.rgb.g;
            hdmi_b_o     <= pixel_o.rgb.b;
            hdmi_hsync_o <= hsync_o;
            hdmi_vsync_o <= vsync_o;
            hdmi_de_o    <= de_o;
        end
    end

endmodule

// File: hw/output_csc.sv
// RGB to YPbPr colour converter for the analog output
// Stage 1 forms the nine products, stage 2 sums, shifts, offsets and clamps.
// Outside YPbPr mode the RGB word is delayed unchanged.

module output_csc import video_out_pkg::*; (
    input  logic       pclk_out,
    input  logic       po_reset_n,
    input  pixel_u     pixel_i,
    input  logic [1:0] mode_i,
    output pixel_u     pixel_o
);

    logic signed [PIX_W:0] r_s;
    logic signed [PIX_W:0] g_s;
    logic signed [PIX_W:0] b_s;

    logic signed [17:0] prod_y  [3];
    logic signed [17:0] prod_pb [3];
    logic signed [17:0] prod_pr [3];
    pixel_u             pix_q;
    logic               ypbpr_q;

    // Sum one product triple and clamp to the channel range
    function automatic logic [PIX_W-1:0] sum_clamp(
        input logic signed [17:0] a,
        input logic signed [17:0] b,
        input logic signed [17:0] c,
        input logic               add_ofs
    );
        logic signed [19:0] acc;
        acc = a;
        acc = acc + b;
        acc = acc + c;
        acc = acc >>> CSC_SHIFT;
        if (add_ofs) begin
            acc = acc + 20'(CHROMA_OFS);
        end
        if (acc[19]) begin
            return '0;
        end else if (acc > 20'sd255) begin
            return '1;
        end
        return acc[PIX_W-1:0];
    endfunction

    // Channels are unsigned, widen before the signed multiply
    assign r_s = $signed({1'b0, pixel_i.rgb.r});
    assign g_s = $signed({1'b0, pixel_i.rgb.g});
    assign b_s = $signed({1'b0, pixel_i.rgb.b});

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            prod_y  <= '{default: '0};
            prod_pb <= '{default: '0};
            prod_pr <= '{default: '0};
            pix_q   <= '0;
            ypbpr_q <= 1'b0;
        end else begin
            prod_y[0]  <= r_s * CSC_Y_R;
            prod_y[1]  <= g_s * CSC_Y_G;
            prod_y[2]  <= b_s * CSC_Y_B;
            prod_pb[0] <= r_s * CSC_PB_R;
            prod_pb[1] <= g_s * CSC_PB_G;
            prod_pb[2] <= b_s * CSC_PB_B;
            prod_pr[0] <= r_s * CSC_PR_R;
            prod_pr[1] <= g_s * CSC_PR_G;
            prod_pr[2] <= b_s * CSC_PR_B;
            pix_q      <= pixel_i;
            ypbpr_q    <= (mode_i == MODE_YPBPR);
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pixel_o <= '0;
        end else if (ypbpr_q) begin
            pixel_o.ypbpr.y  <= sum_clamp(prod_y[0], prod_y[1], prod_y[2], 1'b0);
            pixel_o.ypbpr.pb <= sum_clamp(prod_pb[0], prod_pb[1], prod_pb[2], 1'b1);
            pixel_o.ypbpr.pr <= sum_clamp(prod_pr[0], prod_pr[1], prod_pr[2], 1'b1);
        end else begin
            pixel_o <= pix_q;
        end
    end

endmodule

// File: hw/sync_encoder.sv
// Analog sync and blank encoder
// Builds hs, vs, blank_n and sync_n for the selected output mode,
// delayed two cycles to line up with the colour converter

module sync_encoder import video_out_pkg::*; (
    input  logic       pclk_out,
    input  logic       po_reset_n,
    input  logic       hsync_i,
    input  logic       vsync_i,
    input  logic       de_i,
    input  logic [1:0] mode_i,
    output logic       hs_o,
    output logic       vs_o,
    output logic       blank_n_o,
    output logic       sync_n_o
);

    logic       csync;
    logic [3:0] enc;
    logic [3:0] enc_q;

    assign csync = ~(hsync_i ^ vsync_i);

    // Order is {hs, vs, blank_n, sync_n}
    always_comb begin
        case (mode_i)
            MODE_RGBHV: enc = {hsync_i, vsync_i, de_i, 1'b0};
            MODE_RGBCS: enc = {csync, 1'b1, de_i, 1'b0};
            MODE_RGSB:  enc = {csync, 1'b1, de_i, csync};
            default:    enc = {csync, 1'b1, 1'b1, csync};
        endcase
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            enc_q     <= '0;
            hs_o      <= 1'b0;
            vs_o      <= 1'b0;
            blank_n_o <= 1'b0;
            sync_n_o  <= 1'b0;
        end else begin
            enc_q     <= enc;
            hs_o      <= enc_q[3];
            vs_o      <= enc_q[2];
            blank_n_o <= enc_q[1];
            sync_n_o  <= enc_q[0];
        end
    end

endmodule

// File: hw/dac_formatter.sv
// Video DAC output registers
// Pre-stage and final stage for pixel and syncs, frozen while the
// extra output is disabled; power-save and mute follow poweron

module dac_formatter import video_out_pkg::*; (
    input  logic             pclk_out,
    input  logic             po_reset_n,
    input  pixel_u           pixel_i,
    input  logic             hs_i,
    input  logic             vs_i,
    input  logic             blank_n_i,
    input  logic             sync_n_i,
    input  logic             ext_out_en_i,
    input  logic             poweron_i,
    output logic [PIX_W-1:0] dac_r_o,
    output logic [PIX_W-1:0] dac_g_o,
    output logic [PIX_W-1:0] dac_b_o,
    output logic             dac_hs_o,
    output logic             dac_vs_o,
    output logic             dac_blank_n_o,
    output logic             dac_sync_n_o,
    output logic             dac_psave_n_o,
    output logic             audio_mute_n_o
);

    pixel_u pix_pre;
    logic   hs_pre;
    logic   vs_pre;
    logic   blank_n_pre;
    logic   sync_n_pre;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pix_pre       <= '0;
            hs_pre        <= 1'b0;
            vs_pre        <= 1'b0;
            blank_n_pre   <= 1'b0;
            sync_n_pre    <= 1'b0;
            dac_r_o       <= '0;
            dac_g_o       <= '0;
            dac_b_o       <= '0;
            dac_hs_o      <= 1'b0;
            dac_vs_o      <= 1'b0;
            dac_blank_n_o <= 1'b0;
            dac_sync_n_o  <= 1'b0;
        end else if (ext_out_en_i) begin
            pix_pre       <= pixel_i;
            hs_pre        <= hs_i;
            vs_pre        <= vs_i;
            blank_n_pre   <= blank_n_i;
            sync_n_pre    <= sync_n_i;
            // YPbPr lands on the same channels through the rgb view
            dac_r_o       <= pix_pre.rgb.r;
            dac_g_o       <= pix_pre.rgb.g;
            dac_b_o       <= pix_pre.rgb.b;
            dac_hs_o      <= hs_pre;
            dac_vs_o      <= vs_pre;
            dac_blank_n_o <= blank_n_pre;
            dac_sync_n_o  <= sync_n_pre;
        end
    end

    assign dac_psave_n_o  = poweron_i;
    assign audio_mute_n_o = poweron_i;

endmodule

// File: hw/video_out_top.sv
// Video output stage top level
// OSD mixer feeds the HDMI transmitter and, in parallel, the colour
// converter and sync encoder whose results meet in the DAC formatter

module video_out_top (
    input  logic       pclk_out,
    input  logic       po_reset_n,
    input  logic [7:0] r_i,
    input  logic [7:0] g_i,
    input  logic [7:0] b_i,
    input  logic       hsync_i,
    input  logic       vsync_i,
    input  logic       de_i,
    input  logic       osd_enable_i,
    input  logic [2:0] osd_color_i,
    input  logic       poweron_i,
    input  logic       ext_out_en_i,
    input  logic [1:0] ext_out_mode_i,
    output logic [7:0] hdmi_r_o,
    output logic [7:0] hdmi_g_o,
    output logic [7:0] hdmi_b_o,
    output logic       hdmi_hsync_o,
    output logic       hdmi_vsync_o,
    output logic       hdmi_de_o,
    output logic [7:0] dac_r_o,
    output logic [7:0] dac_g_o,
    output logic [7:0] dac_b_o,
    output logic       dac_hs_o,
    output logic       dac_vs_o,
    output logic       dac_blank_n_o,
    output logic       dac_sync_n_o,
    output logic       dac_psave_n_o,
    output logic       audio_mute_n_o
);

    // Overlaid first stage
    logic [23:0] mix_pixel;
    logic        mix_hsync;
    logic        mix_vsync;
    logic        mix_de;

    logic [23:0] csc_pixel;
    logic        enc_hs;
    logic        enc_vs;
    logic        enc_blank_n;
    logic        enc_sync_n;

    osd_mixer i_osd_mixer (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .r_i          (r_i),
        .g_i          (g_i),
        .b_i          (b_i),
        .hsync_i      (hsync_i),
        .vsync_i      (vsync_i),
        .de_i         (de_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .pixel_o      (mix_pixel),
        .hsync_o      (mix_hsync),
        .vsync_o      (mix_vsync),
        .de_o         (mix_de),
        .hdmi_r_o     (hdmi_r_o),
        .hdmi_g_o     (hdmi_g_o),
        .hdmi_b_o     (hdmi_b_o),
        .hdmi_hsync_o (hdmi_hsync_o),
        .hdmi_vsync_o (hdmi_vsync_o),
        .hdmi_de_o    (hdmi_de_o)
    );

    output_csc i_output_csc (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .pixel_i    (mix_pixel),
        .mode_i     (ext_out_mode_i),
        .pixel_o    (csc_pixel)
    );

    sync_encoder i_sync_encoder (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .hsync_i    (mix_hsync),
        .vsync_i    (mix_vsync),
        .de_i       (mix_de),
        .mode_i     (ext_out_mode_i),
        .hs_o       (enc_hs),
        .vs_o       (enc_vs),
        .blank_n_o  (enc_blank_n),
        .sync_n_o   (enc_sync_n)
    );

    dac_formatter i_dac_formatter (
        .pclk_out       (pclk_out),
        .po_reset_n     (po_reset_n),
        .pixel_i        (csc_pixel),
        .hs_i           (enc_hs),
        .vs_i           (enc_vs),
        .blank_n_i      (enc_blank_n),
        .sync_n_i       (enc_sync_n),
        .ext_out_en_i   (ext_out_en_i),
        .poweron_i      (poweron_i),
        .dac_r_o        (dac_r_o),
        .dac_g_o        (dac_g_o),
        .dac_b_o        (dac_b_o),
        .dac_hs_o       (dac_hs_o),
        .dac_vs_o       (dac_vs_o),
        .dac_blank_n_o  (dac_blank_n_o),
        .dac_sync_n_o   (dac_sync_n_o),
        .dac_psave_n_o  (dac_psave_n_o),
        .audio_mute_n_o (audio_mute_n_o)
    );

endmodule

// File: verif/video_out_model.svh
// Reference model for the video output stage
// OSD overlay, BT.709 RGB to YPbPr conversion and analog sync encoding

`ifndef VIDEO_OUT_MODEL_SVH
`define VIDEO_OUT_MODEL_SVH

// Each OSD colour bit fills a whole channel
function automatic logic [23:0] overlay_ref(input logic [23:0] pix, input logic osd_en,
                                            input logic [2:0] color);
    if (osd_en) begin
        return {{8{color[2]}}, {8{color[1]}}, {8{color[0]}}};
    end
    return pix;
endfunction

// Weighted sum scaled by 256, floor shift, offset, clamp to 8 bits
function automatic logic [7:0] csc_ref(input logic [23:0] pix, input int kr, input int kg,
                                       input int kb, input int ofs);
    int acc;
    acc = int'(pix[23:16]) * kr + int'(pix[15:8]) * kg + int'(pix[7:0]) * kb;
    acc = (acc >>> 8) + ofs;
    if (acc < 0) begin
        return 8'd0;
    end else if (acc > 255) begin
        return 8'd255;
    end
    return 8'(acc);
endfunction

// Pr on red, Y on green, Pb on blue
function automatic logic [23:0] dac_pixel_ref(input logic [23:0] pix, input logic [1:0] mode);
    if (mode != MODE_YPBPR) begin
        return pix;
    end
    return {csc_ref(pix, 112, -102, -10, 128),
            csc_ref(pix, 47, 157, 16, 0),
            csc_ref(pix, -26, -86, 112, 128)};
endfunction

// Result is {hs, vs, blank_n, sync_n}
function automatic logic [3:0] sync_ref(input logic hs, input logic vs, input logic de,
                                        input logic [1:0] mode);
    logic       cs;
    logic [3:0] res;
    cs = ~(hs ^ vs);
    res = (mode == MODE_RGBHV) ? {hs, vs, de, 1'b0} : {cs, 1'b1, de, 1'b0};
    if (mode == MODE_RGSB || mode == MODE_YPBPR) begin
        res[0] = cs;
    end
    if (mode == MODE_YPBPR) begin
        res[1] = 1'b1;
    end
    return res;
endfunction

`endif

// File: verif/tb_video_out.sv
// Testbench for the video output stage
// Random and corner pixels through all extra-output modes, compared
// on the HDMI and DAC ports against the reference model

module tb_video_out import video_out_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    `include "video_out_model.svh"

    // One input cycle as the DUT samples it
    typedef struct packed {
        logic [23:0] pix;
        logic        hs;
        logic        vs;
        logic        de;
        logic        osd_en;
        logic [2:0]  osd_color;
        logic        en;
        logic [1:0]  mode;
    } sample_t;

    logic       pclk_out;
    logic       po_reset_n;
    logic [7:0] r_i;
    logic [7:0] g_i;
    logic [7:0] b_i;
    logic       hsync_i;
    logic       vsync_i;
    logic       de_i;
    logic       osd_enable_i;
    logic [2:0] osd_color_i;
    logic       poweron_i;
    logic       ext_out_en_i;
    logic [1:0] ext_out_mode_i;
    logic [7:0] hdmi_r_o;
    logic [7:0] hdmi_g_o;
    logic [7:0] hdmi_b_o;
    logic       hdmi_hsync_o;
    logic       hdmi_vsync_o;
    logic       hdmi_de_o;
    logic [7:0] dac_r_o;
    logic [7:0] dac_g_o;
    logic [7:0] dac_b_o;
    logic       dac_hs_o;
    logic       dac_vs_o;
    logic       dac_blank_n_o;
    logic       dac_sync_n_o;
    logic       dac_psave_n_o;
    logic       audio_mute_n_o;

    integer      seed;
    int          error_count = 0;
    int          check_count = 0;
    int          dac_checks = 0;
    bit          run_checks = 1'b0;
    bit          timed_out = 1'b0;
    sample_t     hist[$];
    logic [23:0] last_pix;
    logic [3:0]  last_sync;

    video_out_top i_video_out_top (.*);

    always #10 pclk_out = ~pclk_out;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("ERROR %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic check_hdmi(input logic [23:0] pix, input logic [2:0] syncs);
        check_value("hdmi_r_o", 32'(pix[23:16]), 32'(hdmi_r_o));
        check_value("hdmi_g_o", 32'(pix[15:8]), 32'(hdmi_g_o));
        check_value("hdmi_b_o", 32'(pix[7:0]), 32'(hdmi_b_o));
        check_value("hdmi_hsync_o", 32'(syncs[2]), 32'(hdmi_hsync_o));
        check_value("hdmi_vsync_o", 32'(syncs[1]), 32'(hdmi_vsync_o));
        check_value("hdmi_de_o", 32'(syncs[0]), 32'(hdmi_de_o));
    endtask

    task automatic check_dac(input logic [23:0] pix, input logic [3:0] syncs);
        check_value("dac_r_o", 32'(pix[23:16]), 32'(dac_r_o));
        check_value("dac_g_o", 32'(pix[15:8]), 32'(dac_g_o));
        check_value("dac_b_o", 32'(pix[7:0]), 32'(dac_b_o));
        check_value("dac_hs_o", 32'(syncs[3]), 32'(dac_hs_o));
        check_value("dac_vs_o", 32'(syncs[2]), 32'(dac_vs_o));
        check_value("dac_blank_n_o", 32'(syncs[1]), 32'(dac_blank_n_o));
        check_value("dac_sync_n_o", 32'(syncs[0]), 32'(dac_sync_n_o));
    endtask

    task automatic drive_random(input int cycles, input bit use_osd, input bit en,
                                input logic [1:0] mode, input bit pwr);
        for (int i = 0; i < cycles; i++) begin
            @(posedge pclk_out);
            {r_i, g_i, b_i} <= 24'($random(seed));
            {hsync_i, vsync_i, de_i, osd_color_i} <= 6'($random(seed));
            osd_enable_i   <= use_osd && (($random(seed) & 3) == 0);
            ext_out_en_i   <= en;
            ext_out_mode_i <= mode;
            poweron_i      <= pwr;
        end
    endtask

    // Black, white and the saturated primaries and secondaries
    task automatic drive_corners();
        for (int k = 0; k < 16; k++) begin
            @(posedge pclk_out);
            {r_i, g_i, b_i} <= {{8{k[2]}}, {8{k[1]}}, {8{k[0]}}};
            osd_enable_i    <= 1'b0;
        end
    endtask

    task automatic wait_dac_checks(input int count);
        int target;
        int cycles;
        target = dac_checks + count;
        cycles = 0;
        while (dac_checks < target && cycles < 100) begin
            @(posedge pclk_out);
            cycles++;
        end
        if (dac_checks < target) begin
            timed_out = 1'b1;
            $display("Timeout: the DAC outputs were never compared within 100 cycles");
        end
    endtask

    always @(negedge pclk_out) begin : compare
        sample_t     cur;
        logic [23:0] exp_pix;
        bit          window_ok;
        if (run_checks) begin
            cur = {r_i, g_i, b_i, hsync_i, vsync_i, de_i, osd_enable_i, osd_color_i,
                   ext_out_en_i, ext_out_mode_i};
            hist.push_front(cur);
            if (hist.size() > 6) begin
                void'(hist.pop_back());
            end
            check_value("dac_psave_n_o", 32'(poweron_i), 32'(dac_psave_n_o));
            check_value("audio_mute_n_o", 32'(poweron_i), 32'(audio_mute_n_o));
            if (hist.size() > 2) begin
                check_hdmi(overlay_ref(hist[2].pix, hist[2].osd_en, hist[2].osd_color),
                           {hist[2].hs, hist[2].vs, hist[2].de});
            end
            // DAC path needs five cycles of steady enable and mode
            window_ok = (hist.size() == 6);
            if (window_ok) begin
                for (int i = 1; i < 6; i++) begin
                    if (!hist[i].en || hist[i].mode != hist[5].mode) begin
                        window_ok = 1'b0;
                    end
                end
            end
            if (window_ok) begin
                exp_pix = overlay_ref(hist[5].pix, hist[5].osd_en, hist[5].osd_color);
                check_dac(dac_pixel_ref(exp_pix, hist[5].mode),
                          sync_ref(hist[5].hs, hist[5].vs, hist[5].de, hist[5].mode));
                dac_checks++;
            end else if (hist.size() > 1 && !hist[1].en) begin
                check_dac(last_pix, last_sync);
            end
            last_pix  = {dac_r_o, dac_g_o, dac_b_o};
            last_sync = {dac_hs_o, dac_vs_o, dac_blank_n_o, dac_sync_n_o};
        end
    end

    initial begin
        seed            = 32'h3403_2d92;
        pclk_out        = 1'b0;
        po_reset_n      = 1'b0;
        // Active stream while in reset
        {r_i, g_i, b_i} = 24'hff_ffff;
        hsync_i         = 1'b1;
        vsync_i         = 1'b1;
        de_i            = 1'b1;
        osd_enable_i    = 1'b0;
        osd_color_i     = 3'b000;
        poweron_i       = 1'b0;
        ext_out_en_i    = 1'b1;
        ext_out_mode_i  = MODE_YPBPR;

        repeat (7) @(posedge pclk_out);
        @(negedge pclk_out);
        check_hdmi(24'h0, 3'b000);
        check_dac(24'h0, 4'b0000);
        check_value("dac_psave_n_o", 32'h0, 32'(dac_psave_n_o));
        check_value("audio_mute_n_o", 32'h0, 32'(audio_mute_n_o));
        @(posedge pclk_out);
        po_reset_n <= 1'b1;
        run_checks <= 1'b1;

        drive_random(40, 1'b0, 1'b1, MODE_RGBHV, 1'b1);
        drive_random(30, 1'b1, 1'b1, MODE_RGBHV, 1'b1);
        wait_dac_checks(1);
        drive_random(40, 1'b1, 1'b1, MODE_RGBCS, 1'b0);
        wait_dac_checks(1);
        drive_random(40, 1'b1, 1'b1, MODE_RGSB, 1'b1);
        wait_dac_checks(1);
        drive_random(10, 1'b0, 1'b1, MODE_YPBPR, 1'b1);
        drive_corners();
        drive_random(40, 1'b1, 1'b1, MODE_YPBPR, 1'b0);
        wait_dac_checks(1);
        // DAC frozen while the HDMI stream keeps running
        drive_random(20, 1'b1, 1'b0, MODE_YPBPR, 1'b0);
        drive_random(10, 1'b0, 1'b0, MODE_RGBHV, 1'b1);
        drive_random(30, 1'b1, 1'b1, MODE_RGBCS, 1'b1);
        wait_dac_checks(6);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+verif
hw/video_out_pkg.sv
hw/osd_mixer.sv
hw/output_csc.sv
hw/sync_encoder.sv
hw/dac_formatter.sv
hw/video_out_top.sv
verif/tb_video_out.sv

// File: run.sh
#!/bin/sh
# Compile and run the video output testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module tb_video_out \
    -f project.f --Mdir obj_dir -o sim_video_out

result=$(./obj_dir/sim_video_out)
echo "$result"

if echo "$result" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
